// File: Makefile
TOP = tb_boot_uart

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

# the simulator's output is echoed, then searched for the pass line.
run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Regression passed"

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: logic/boot_pkg.sv
`default_nettype none

package boot_pkg;

  // uart line timing, kept short for simulation.
  localparam int baud_div = 16;
  localparam int frame_bits = 10; // start, eight data, stop.

  localparam int queue_depth = 8;

  typedef logic [$clog2(baud_div)-1:0] baud_cnt_t;
  typedef logic [$clog2(queue_depth)-1:0] qptr_t;
  typedef logic [$clog2(queue_depth):0] qcnt_t; // one extra bit to count a full buffer.

  // one load or debug word, seen whole or as bytes.
  // bytes[0] is the least significant byte.
  typedef union packed {
    logic [31:0] word;
    logic [3:0][7:0] bytes;
  } boot_word_u;

  typedef struct packed {
    logic valid; // single cycle.
    logic [7:0] data;
  } rx_byte_t;

  typedef struct packed {
    logic strobe;
    logic [31:0] addr;
    boot_word_u data;
  } load_t;

endpackage

`default_nettype wire

// File: logic/boot_uart.sv
`default_nettype none

module boot_uart (
  input wire clk,
  input wire rst_n,
  input wire rx,
  output logic tx,
  input wire debug,
  output boot_pkg::load_t load,
  input wire [31:0] dbg_data,
  input wire dbg_push
);

  boot_pkg::rx_byte_t rx_byte;
  logic [31:0] q_head;
  logic q_empty;
  logic q_pop;
  logic tx_start;
  logic [7:0] tx_byte;
  logic tx_done;

  // host to processor.
  uart_rx u_rx (.clk(clk), .rst_n(rst_n), .rx(rx), .byte_out(rx_byte));

  word_assembler u_asm (
    .clk(clk), .rst_n(rst_n), .debug(debug), .byte_in(rx_byte), .load(load)
  );

  // processor to host.
  debug_queue u_queue (
    .clk(clk), .rst_n(rst_n), .push(dbg_push), .push_data(dbg_data),
    .pop(q_pop), .head(q_head), .empty(q_empty)
  );

  word_serializer u_ser (
    .clk(clk), .rst_n(rst_n), .head(q_head), .empty(q_empty), .tx_done(tx_done),
    .pop(q_pop), .tx_start(tx_start), .tx_byte(tx_byte)
  );

  uart_tx u_tx (
    .clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_byte(tx_byte),
    .tx(tx), .tx_done(tx_done)
  );

endmodule

`default_nettype wire

// File: logic/debug_queue.sv
`default_nettype none

module debug_queue (
  input wire clk,
  input wire rst_n,
  input wire push,
  input wire [31:0] push_data,
  input wire pop,
  output logic [31:0] head,
  output logic empty
);

  logic [31:0] mem [boot_pkg::queue_depth];
  boot_pkg::qptr_t wr_ptr;
  boot_pkg::qptr_t rd_ptr;
  boot_pkg::qcnt_t count;
  logic full;
  logic do_push;
  logic do_pop;

  function automatic boot_pkg::qptr_t next_ptr(input boot_pkg::qptr_t ptr);
    if (ptr == boot_pkg::qptr_t'(boot_pkg::queue_depth - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign full = count == boot_pkg::qcnt_t'(boot_pkg::queue_depth);
  assign empty = count == '0;
  assign do_push = push && !full; // a full buffer drops the word.
  assign do_pop = pop && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count; // both or neither.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  assign head = mem[rd_ptr];

endmodule

`default_nettype wire

// File: logic/uart_rx.sv
`default_nettype none

module uart_rx (
  input wire clk,
  input wire rst_n,
  input wire rx,
  output boot_pkg::rx_byte_t byte_out
);

  typedef enum logic [1:0] {s_idle, s_start, s_data, s_stop} state_t;

  state_t state;
  logic [1:0] sync;
  logic rx_q; // previous synchronized sample.
  boot_pkg::baud_cnt_t baud_cnt;
  logic [2:0] bit_cnt;
  logic [7:0] shifter;
  logic valid_q;
  logic half_end;
  logic bit_end;

  assign half_end = baud_cnt == boot_pkg::baud_cnt_t'(boot_pkg::baud_div / 2 - 1);
  assign bit_end = baud_cnt == boot_pkg::baud_cnt_t'(boot_pkg::baud_div - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync <= 2'b11; // line idles high.
      rx_q <= 1'b1;
    end else begin
      sync <= {sync[0], rx};
      rx_q <= sync[1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_idle;
      baud_cnt <= '0;
      bit_cnt <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      baud_cnt <= (bit_end || state == s_idle) ? '0 : baud_cnt + 1'b1;
      case (state)
        s_idle: if (rx_q && !sync[1]) state <= s_start;
        s_start: begin
          if (half_end) begin
            // from here on every sample lands mid-bit.
            baud_cnt <= '0;
            bit_cnt <= '0;
            state <= sync[1] ? s_idle : s_data; // glitch, not a start bit.
          end
        end
        s_data: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= s_stop;
          end
        end
        default: begin
          if (bit_end) begin
            valid_q <= sync[1]; // dropped on a bad stop bit.
            state <= s_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_data && bit_end) shifter <= {sync[1], shifter[7:1]}; // lsb first.
  end

  assign byte_out.valid = valid_q;
  assign byte_out.data = shifter;

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
`default_nettype none

module uart_tx (
  input wire clk,
  input wire rst_n,
  input wire tx_start,
  input wire [7:0] tx_byte,
  output logic tx,
  output logic tx_done
);

  logic [boot_pkg::frame_bits-1:0] frame;
  boot_pkg::baud_cnt_t baud_cnt;
  logic [3:0] bit_cnt;
  logic busy;
  logic bit_end;
  logic last_bit;

  assign bit_end = baud_cnt == boot_pkg::baud_cnt_t'(boot_pkg::baud_div - 1);
  assign last_bit = bit_cnt == 4'(boot_pkg::frame_bits - 1);

  // high in the final clock of the stop bit.
  assign tx_done = busy && bit_end && last_bit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame <= '1; // idle line.
      baud_cnt <= '0;
      bit_cnt <= '0;
      busy <= 1'b0;
    end else if (tx_start) begin
      frame <= {1'b1, tx_byte, 1'b0};
      baud_cnt <= '0;
      bit_cnt <= '0;
      busy <= 1'b1;
    end else if (busy) begin
      if (bit_end) begin
        baud_cnt <= '0;
        frame <= {1'b1, frame[boot_pkg::frame_bits-1:1]}; // ones fill in behind.
        if (last_bit) busy <= 1'b0;
        else bit_cnt <= bit_cnt + 1'b1;
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  assign tx = frame[0];

endmodule

`default_nettype wire

// File: logic/word_assembler.sv
`default_nettype none

module word_assembler (
  input wire clk,
  input wire rst_n,
  input wire debug,
  input wire boot_pkg::rx_byte_t byte_in,
  output boot_pkg::load_t load
);

  typedef enum logic {s_collect, s_present} state_t;

  state_t state;
  logic [1:0] byte_cnt;
  logic [31:0] addr;
  boot_pkg::boot_word_u word;
  logic take;

  assign take = debug && byte_in.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_collect;
      byte_cnt <= '0;
      addr <= '0;
    end else if (!debug) begin
      // leaving debug throws away a partial word.
      state <= s_collect;
      byte_cnt <= '0;
      addr <= '0;
    end else begin
      if (take) byte_cnt <= byte_cnt + 1'b1; // wraps after the fourth byte.
      state <= (take && byte_cnt == 2'd3) ? s_present : s_collect;
      if (state == s_present) addr <= addr + 1'b1;
    end
  end

  // new byte enters at the top and walks down.
  always_ff @(posedge clk) begin
    if (take) word.bytes <= {byte_in.data, word.bytes[3:1]};
  end

  assign load.strobe = state == s_present;
  assign load.addr = addr;
  assign load.data = word;

endmodule

`default_nettype wire

// File: logic/word_serializer.sv
`default_nettype none

module word_serializer (
  input wire clk,
  input wire rst_n,
  input wire [31:0] head,
  input wire empty,
  input wire tx_done,
  output logic pop,
  output logic tx_start,
  output logic [7:0] tx_byte
);

  typedef enum logic [1:0] {s_idle, s_start, s_send} state_t;

  state_t state;
  logic [1:0] byte_cnt; // bytes already on the line.
  boot_pkg::boot_word_u word;
  logic last_done;

  assign last_done = tx_done && byte_cnt == 2'd3;

  assign pop = state == s_idle && !empty;
  assign tx_start = state == s_start || (state == s_send && tx_done && !last_done);

  // on a restart the shift has not landed yet.
  // so the next byte still sits at index one.
  assign tx_byte = (state == s_send) ? word.bytes[1] : word.bytes[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_idle;
      byte_cnt <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (!empty) begin
            state <= s_start;
            byte_cnt <= '0;
          end
        end
        s_start: state <= s_send;
        s_send: begin
          if (tx_done) byte_cnt <= byte_cnt + 1'b1;
          if (last_done) state <= s_idle;
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) word.word <= head;
    else if (state == s_send && tx_done) word.bytes <= {8'h00, word.bytes[3:1]};
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+tb
logic/boot_pkg.sv
logic/uart_rx.sv
logic/word_assembler.sv
logic/debug_queue.sv
logic/word_serializer.sv
logic/uart_tx.sv
logic/boot_uart.sv
tb/tb_boot_uart.sv

// File: tb/tb_uart_host.svh
`ifndef TB_UART_HOST_SVH
`define TB_UART_HOST_SVH

// one 8n1 frame on rx, lsb first.
task automatic send_byte(input logic [7:0] data);
  logic [9:0] frame;
  frame = {1'b1, data, 1'b0};
  for (int i = 0; i < 10; i++) begin
    @(negedge clk);
    rx = frame[i];
    repeat (boot_pkg::baud_div - 1) @(negedge clk);
  end
endtask

// decodes frames on tx and checks each against the expected byte.
task automatic watch_tx();
  logic [7:0] data;
  logic [7:0] exp;
  forever begin
    @(negedge clk);
    if (rst_n && !tx) begin
      repeat (boot_pkg::baud_div / 2) @(negedge clk); // mid start bit.
      assert (tx == 1'b0) else log_failure("start bit on tx shorter than half a bit");
      for (int i = 0; i < 8; i++) begin
        repeat (boot_pkg::baud_div) @(negedge clk);
        data[i] = tx;
      end
      repeat (boot_pkg::baud_div) @(negedge clk);
      assert (tx == 1'b1) else log_failure("frame on tx has no valid stop bit");
      tx_frames++;
      if (exp_tx.size() == 0) begin
        log_failure("frame on tx with no debug word pending");
      end else begin
        exp = exp_tx.pop_front();
        assert (data == exp) else log_mismatch("tx byte", {24'd0, exp}, {24'd0, data});
      end
    end
  end
endtask

`endif

// File: tb/tb_boot_uart.sv
`default_nettype none

module tb_boot_uart;

  localparam int frame_cycles = 10 * boot_pkg::baud_div;
  // bytes per test for reset, load, gating, debug out, burst and concurrent.
  localparam int test_bytes = 1 + 32 + 14 + 6 + 34 + 32;
  localparam int cycle_limit = 2 * test_bytes * frame_cycles;

  logic clk;
  logic rst_n;
  logic rx;
  logic tx;
  logic debug;
  boot_pkg::load_t load;
  logic [31:0] dbg_data;
  logic dbg_push;

  logic [31:0] rng;
  logic [31:0] load_idx; // address the next load should show.
  int errors = 0;
  int tests = 0;
  int cycles = 0;
  int tx_frames = 0;
  logic [7:0] exp_tx[$];
  logic [31:0] exp_addr[$];
  logic [31:0] exp_word[$];

  boot_uart uut (
    .clk(clk), .rst_n(rst_n), .rx(rx), .tx(tx), .debug(debug), .load(load),
    .dbg_data(dbg_data), .dbg_push(dbg_push)
  );

  task automatic log_mismatch(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
    errors++;
    $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
  endtask

  task automatic log_failure(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  `include "tb_uart_host.svh"

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: no end of run within %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  // every strobe must match the oldest word sent.
  always @(negedge clk) begin
    if (rst_n && load.strobe) begin
      if (exp_addr.size() == 0) begin
        log_failure("load strobe with no complete word sent");
      end else begin
        assert (load.addr == exp_addr[0]) else log_mismatch("load.addr", exp_addr[0], load.addr);
        assert (load.data.word == exp_word[0])
          else log_mismatch("load.data", exp_word[0], load.data.word);
        void'(exp_addr.pop_front());
        void'(exp_word.pop_front());
      end
    end
  end

  strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
    load.strobe |=> !load.strobe)
    else log_failure("load strobe lasted more than one cycle");

  // sampled after the first clock edge has applied reset.
  reset_quiet: assert property (@(negedge clk) !rst_n |-> tx && !load.strobe)
    else log_failure("tx low or load strobe high during reset");

  task automatic send_word(input logic [31:0] w);
    exp_addr.push_back(load_idx);
    exp_word.push_back(w);
    load_idx++;
    for (int i = 0; i < 4; i++) send_byte(w[8*i +: 8]);
  endtask

  // leaves dbg_push high for the caller to drop.
  task automatic push_debug(input logic [31:0] w);
    for (int i = 0; i < 4; i++) exp_tx.push_back(w[8*i +: 8]);
    @(negedge clk);
    dbg_data = w;
    dbg_push = 1'b1;
  endtask

  task automatic drain_loads();
    int n;
    n = 0;
    while (exp_addr.size() != 0 && n < frame_cycles) begin
      @(negedge clk);
      n++;
    end
    if (exp_addr.size() != 0) begin
      log_failure("load strobe missing after the last byte of a word");
      exp_addr.delete();
      exp_word.delete();
    end
  endtask

  task automatic drain_tx();
    int n;
    int limit;
    n = 0;
    limit = (exp_tx.size() + 1) * frame_cycles;
    while (exp_tx.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (exp_tx.size() != 0) begin
      log_failure("debug bytes never appeared on tx");
      exp_tx.delete();
    end
  endtask

  task automatic end_test(input string name, input int mark);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - mark);
  endtask

  initial begin
    int mark;
    int frames_before;
    logic [31:0] w;
    logic [31:0] words[8];
    clk = 1'b0;
    rst_n = 1'b0;
    rx = 1'b1;
    debug = 1'b0;
    dbg_data = '0;
    dbg_push = 1'b0;
    rng = 32'hd119_4616;
    load_idx = '0;
    fork
      watch_tx();
    join_none
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    mark = errors;
    for (int i = 0; i < frame_cycles; i++) begin
      @(negedge clk);
      assert (tx == 1'b1) else log_mismatch("tx", 32'd1, {31'd0, tx});
      assert (!load.strobe) else log_failure("load strobe without any rx traffic");
    end
    end_test("reset state", mark);

    mark = errors;
    debug = 1'b1;
    for (int i = 0; i < 8; i++) send_word(next_rand());
    drain_loads();
    end_test("word loading", mark);

    mark = errors;
    send_word(next_rand());
    drain_loads();
    @(negedge clk);
    debug = 1'b0;
    load_idx = '0;
    repeat (4) @(negedge clk);
    debug = 1'b1;
    send_word(next_rand()); // back at address zero.
    drain_loads();
    w = next_rand();
    send_byte(w[7:0]);
    send_byte(w[15:8]);
    @(negedge clk);
    debug = 1'b0; // half a word thrown away.
    load_idx = '0;
    repeat (4) @(negedge clk);
    debug = 1'b1;
    send_word(next_rand());
    drain_loads();
    end_test("debug gating", mark);

    mark = errors;
    frames_before = tx_frames;
    push_debug(next_rand());
    @(negedge clk);
    dbg_push = 1'b0;
    drain_tx();
    repeat (2 * frame_cycles) @(negedge clk); // room for a stray frame.
    assert (tx_frames - frames_before == 4)
      else log_mismatch("tx frame count", 32'd4, 32'(tx_frames - frames_before));
    end_test("debug output", mark);

    mark = errors;
    frames_before = tx_frames;
    for (int i = 0; i < boot_pkg::queue_depth; i++) push_debug(next_rand());
    @(negedge clk);
    dbg_push = 1'b0;
    drain_tx();
    repeat (2 * frame_cycles) @(negedge clk);
    assert (tx_frames - frames_before == 4 * boot_pkg::queue_depth)
      else log_mismatch("tx frame count", 32'(4 * boot_pkg::queue_depth),
                        32'(tx_frames - frames_before));
    end_test("buffered burst", mark);

    mark = errors;
    for (int i = 0; i < 8; i++) words[i] = next_rand();
    fork
      for (int i = 0; i < 4; i++) send_word(words[i]);
      begin
        for (int i = 4; i < 8; i++) push_debug(words[i]);
        @(negedge clk);
        dbg_push = 1'b0;
      end
    join
    drain_loads();
    drain_tx();
    end_test("concurrent traffic", mark);

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
